// ==== verilog.f ====
+incdir+verilog
verilog/adc_spi_pkg.sv
verilog/adc_sclk_gen.sv
verilog/adc_frame_ctrl.sv
verilog/adc_shift_capture.sv
verilog/adc_sample_avg.sv
verilog/adc_spi_rx.sv
tb/adc_clk_gen.sv
tb/adc_slave_model.sv
tb/adc_spi_properties.sv
tb/tb_adc_spi_rx.sv

// ==== tb/adc_spi_vectors.hex ====
// One 10-bit ADC sample per line, served one per frame in order.
// Each run of four lines forms one averaging group.
3ff
000
2aa
155
200
1ff
001
3fe
0f3
28c
37a
064
3ff
3ff
3ff
3fe

// ==== tb/tb_adc_spi_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module tb_adc_spi_rx;

  import adc_spi_pkg::*;

  localparam int H            = `ADC_SCLK_HALF;
  localparam int NUM_VEC      = 16;
  localparam int AVG_N        = 1 << `ADC_AVG_LOG2;
  localparam int NUM_BURST    = 4;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_WATCH   = 50;
  localparam int MID_FRAME    = 100;     // Cycles into the last frame before rx_en drops.
  localparam int MIN_GAP      = 20;
  localparam int GAP_SPAN     = 40;
  localparam int TIMEOUT_CYCLES = NUM_VEC * (34 * H + 20) + NUM_BURST * (MIN_GAP + GAP_SPAN)
                                  + IDLE_WATCH + RESET_CYCLES;

  logic        clk;
  logic        rst;
  logic        rx_en;
  logic        spi_sdata;
  logic        spi_cs_n;
  logic        spi_sclk;
  adc_sample_s sample;
  adc_avg_s    average;

  adc_sample_t vectors [NUM_VEC];
  adc_sample_t adc_value;
  integer      seed;
  int          cycle_cnt      = 0;
  int          frames_started = 0;
  int          samples_seen   = 0;
  int          avg_seen       = 0;
  int          low_cnt        = 0;
  int          high_cnt       = 0;
  int          fall_cnt       = 0;
  int          sum;
  logic        cs_prev        = 1'b1;
  logic        sclk_prev      = 1'b1;
  logic        gap_all_en     = 1'b0;

  adc_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  adc_slave_model u_adc (
    .spi_cs_n  (spi_cs_n),
    .spi_sclk  (spi_sclk),
    .value     (adc_value),
    .spi_sdata (spi_sdata)
  );

  adc_spi_rx u_dut (
    .clk       (clk),
    .rst       (rst),
    .rx_en     (rx_en),
    .spi_sdata (spi_sdata),
    .spi_cs_n  (spi_cs_n),
    .spi_sclk  (spi_sclk),
    .sample    (sample),
    .average   (average)
  );

  bind adc_spi_rx adc_spi_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .spi_cs_n      (spi_cs_n),
    .spi_sclk      (spi_sclk),
    .sample_valid  (sample.valid),
    .average_valid (average.valid)
  );

  task automatic report_failure(input string what);
    begin
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_sample(input adc_sample_t got, input adc_sample_t exp, input int idx);
    if (got !== exp)
    begin
      report_failure($sformatf("Mismatch sample.data (sample %0d): got 0x%h, expected 0x%h",
                               idx, got, exp));
    end
  endtask

  task automatic check_average(input adc_sample_t got, input adc_sample_t exp, input int idx);
    if (got !== exp)
    begin
      report_failure($sformatf("Mismatch average.mean (group %0d): got 0x%h, expected 0x%h",
                               idx, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic watch_idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      if (spi_cs_n !== 1'b1 || spi_sclk !== 1'b1)
      begin
        report_failure("spi_cs_n or spi_sclk left the idle level while rx_en was low");
      end
      if (sample.valid !== 1'b0 || average.valid !== 1'b0)
      begin
        report_failure("A valid pulse appeared while no frame was running");
      end
    end
  endtask

  // Holds rx_en for n frames, drops it inside the last one, then checks the idle gap.
  task automatic run_burst(input int n);
    int target;
    int gap;
    begin
      target = frames_started + n;
      @(posedge clk);
      #1 rx_en = 1'b1;
      wait (frames_started == target);
      repeat (MID_FRAME) @(posedge clk);
      #1 rx_en = 1'b0;
      wait (samples_seen == target);
      repeat (2) @(negedge clk);          // Let a pending average go by.
      gap = MIN_GAP + ($unsigned($random(seed)) % GAP_SPAN);
      watch_idle(gap);
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      report_failure($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  always @(u_dut.u_props.fail_count)
  begin
    if (u_dut.u_props.fail_count != 0)
    begin
      report_failure("A pin protocol assertion failed");
    end
  end

  // Frame timing and result monitor.
  always @(negedge clk)
  begin
    if (rst)
    begin
      if (cs_prev && !spi_cs_n)
      begin
        if (frames_started >= NUM_VEC)
        begin
          report_failure("A frame started with no vector left");
        end
        if (frames_started > 0 && gap_all_en)
        begin
          check_count("spi_cs_n high cycles between frames", high_cnt, H);
        end
        frames_started = frames_started + 1;
        if (frames_started < NUM_VEC)
        begin
          adc_value = vectors[frames_started];
        end
        low_cnt  = 1;
        fall_cnt = 0;
      end
      else if (!spi_cs_n)
      begin
        low_cnt = low_cnt + 1;
        if (sclk_prev && !spi_sclk)
        begin
          fall_cnt = fall_cnt + 1;
        end
      end
      else if (!cs_prev)
      begin
        check_count("spi_cs_n low cycles", low_cnt, 33 * H);
        check_count("spi_sclk falling edges in frame", fall_cnt, `ADC_FRAME_BITS);
        high_cnt   = 1;
        gap_all_en = rx_en;
      end
      else
      begin
        high_cnt   = high_cnt + 1;
        gap_all_en = gap_all_en && rx_en;
      end

      if (sample.valid)
      begin
        if (samples_seen >= NUM_VEC)
        begin
          report_failure("sample.valid pulsed with no vector left");
        end
        check_sample(sample.data, vectors[samples_seen], samples_seen);
        samples_seen = samples_seen + 1;
      end

      if (average.valid)
      begin
        if (samples_seen != (avg_seen + 1) * AVG_N)
        begin
          report_failure("average.valid pulsed outside the end of a group of samples");
        end
        sum = 0;
        for (int i = 0; i < AVG_N; i++)
        begin
          sum = sum + int'(vectors[avg_seen * AVG_N + i]);
        end
        check_average(average.mean, adc_sample_t'(sum / AVG_N), avg_seen);
        avg_seen = avg_seen + 1;
      end

      cs_prev   = spi_cs_n;
      sclk_prev = spi_sclk;
    end
  end

  initial
  begin
    rx_en = 1'b0;
    seed  = 32'h3803_e65d;
    $readmemh("tb/adc_spi_vectors.hex", vectors);
    if (^vectors[NUM_VEC-1] === 1'bx)
    begin
      report_failure("Vector file did not load completely");
    end
    adc_value = vectors[0];

    @(posedge rst);
    watch_idle(IDLE_WATCH);

    run_burst(1);
    run_burst(5);
    run_burst(6);
    run_burst(4);

    if (frames_started == NUM_VEC && samples_seen == NUM_VEC && avg_seen == NUM_VEC / AVG_N)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      report_failure($sformatf("Run ended after %0d frames, %0d samples and %0d averages",
                               frames_started, samples_seen, avg_seen));
    end
  end

endmodule

`default_nettype wire

// ==== tb/adc_spi_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_spi_properties (
  input logic clk,
  input logic rst,
  input logic spi_cs_n,
  input logic spi_sclk,
  input logic sample_valid,
  input logic average_valid
);

  int fail_count = 0;

  sclk_parked_high: assert property (@(posedge clk) disable iff (!rst)
    spi_cs_n |-> spi_sclk)
  else
  begin
    $error("spi_sclk low while spi_cs_n is high");
    fail_count = fail_count + 1;
  end

  sample_single_pulse: assert property (@(posedge clk) disable iff (!rst)
    sample_valid |=> !sample_valid)
  else
  begin
    $error("sample.valid high for two cycles in a row");
    fail_count = fail_count + 1;
  end

  average_single_pulse: assert property (@(posedge clk) disable iff (!rst)
    average_valid |=> !average_valid)
  else
  begin
    $error("average.valid high for two cycles in a row");
    fail_count = fail_count + 1;
  end

  // Quiet gap between frames.
  cs_min_gap: assert property (@(posedge clk) disable iff (!rst)
    $rose(spi_cs_n) |-> spi_cs_n [*`ADC_SCLK_HALF])
  else
  begin
    $error("spi_cs_n high for fewer than one SCLK half period");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// ==== tb/adc_slave_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_slave_model (
  input  logic                     spi_cs_n,
  input  logic                     spi_sclk,
  input  adc_spi_pkg::adc_sample_t value,
  output logic                     spi_sdata
);

  import adc_spi_pkg::*;

  localparam int FRAME_BITS = `ADC_FRAME_BITS;
  localparam int TAIL_BITS  = `ADC_FRAME_BITS - `ADC_LEAD_BITS - `ADC_DATA_BITS;

  logic [FRAME_BITS-1:0] frame_word;
  int                    bit_idx;

  initial
  begin
    spi_sdata  = 1'b0;
    frame_word = '0;
    bit_idx    = 0;
  end

  // Bit 0 goes out as soon as the chip select falls.
  always @(negedge spi_cs_n)
  begin
    frame_word = {{`ADC_LEAD_BITS{1'b0}}, value, {TAIL_BITS{1'b0}}};
    bit_idx    = 0;
    spi_sdata  = frame_word[FRAME_BITS-1];
  end

  always @(negedge spi_sclk)
  begin
    if (!spi_cs_n)
    begin
      bit_idx = bit_idx + 1;
      if (bit_idx < FRAME_BITS)
      begin
        spi_sdata = frame_word[FRAME_BITS-1-bit_idx];
      end
      else
      begin
        spi_sdata = 1'b0;
      end
    end
  end

  always @(posedge spi_cs_n)
  begin
    spi_sdata = 1'b0;                     // Released line reads low.
  end

endmodule

`default_nettype wire

// ==== tb/adc_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b0;                           // Active low, held from time zero.
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/adc_spi_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_spi_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rx_en,
  input  logic                    spi_sdata,
  output logic                    spi_cs_n,
  output logic                    spi_sclk,
  output adc_spi_pkg::adc_sample_s sample,
  output adc_spi_pkg::adc_avg_s    average
);

  logic sclk_run;
  logic sclk_fall;
  logic sclk_mid;
  logic shift_stb;
  logic frame_end;

  adc_frame_ctrl u_frame_ctrl (
    .clk       (clk),
    .rst       (rst),
    .rx_en     (rx_en),
    .sclk_fall (sclk_fall),
    .sclk_mid  (sclk_mid),
    .spi_cs_n  (spi_cs_n),
    .sclk_run  (sclk_run),
    .shift_stb (shift_stb),
    .frame_end (frame_end)
  );

  adc_sclk_gen u_sclk_gen (
    .clk       (clk),
    .rst       (rst),
    .sclk_run  (sclk_run),
    .spi_sclk  (spi_sclk),
    .sclk_fall (sclk_fall),
    .sclk_mid  (sclk_mid)
  );

  adc_shift_capture u_shift_capture (
    .clk       (clk),
    .rst       (rst),
    .spi_sdata (spi_sdata),
    .shift_stb (shift_stb),
    .frame_end (frame_end),
    .sample    (sample)
  );

  // Runs on every captured sample.
  adc_sample_avg u_sample_avg (
    .clk       (clk),
    .rst       (rst),
    .sample    (sample),
    .average   (average)
  );

endmodule

`default_nettype wire

// ==== verilog/adc_sample_avg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_sample_avg (
  input  logic                    clk,
  input  logic                    rst,
  input  adc_spi_pkg::adc_sample_s sample,
  output adc_spi_pkg::adc_avg_s    average
);

  import adc_spi_pkg::*;

  localparam int GRP_W = `ADC_AVG_LOG2;

  adc_sum_t         acc;
  adc_sum_t         acc_nxt;
  logic [GRP_W-1:0] grp_cnt;
  logic             grp_last;
  adc_sample_t      mean;
  logic             avg_valid;

  assign acc_nxt  = acc + adc_sum_t'(sample.data);
  assign grp_last = &grp_cnt;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      acc       <= '0;
      grp_cnt   <= '0;
      avg_valid <= 1'b0;
    end
    else
    begin
      avg_valid <= sample.valid && grp_last;
      if (sample.valid)
      begin
        grp_cnt <= grp_cnt + 1'b1;      // Wraps to zero after the last one.
        acc     <= grp_last ? '0 : acc_nxt;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample.valid && grp_last)
    begin
      mean <= adc_sample_t'(acc_nxt >> GRP_W);  // Floor of the mean.
    end
  end

  assign average.valid = avg_valid;
  assign average.mean  = mean;

endmodule

`default_nettype wire

// ==== verilog/adc_shift_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_shift_capture (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    spi_sdata,
  input  logic                    shift_stb,
  input  logic                    frame_end,
  output adc_spi_pkg::adc_sample_s sample
);

  import adc_spi_pkg::*;

  logic        sdata_meta;
  logic        sdata_sync;
  adc_sample_t shift_reg;
  adc_sample_t sample_data;
  logic        sample_valid;

  always_ff @(posedge clk)
  begin
    sdata_meta <= spi_sdata;
    sdata_sync <= sdata_meta;
  end

  always_ff @(posedge clk)
  begin
    if (frame_end)
    begin
      shift_reg <= '0;
    end
    else if (shift_stb)
    begin
      shift_reg <= {shift_reg[`ADC_DATA_BITS-2:0], sdata_sync};  // MSB first.
    end
  end

  always_ff @(posedge clk)
  begin
    if (frame_end)
    begin
      sample_data <= shift_reg;
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= frame_end;
    end
  end

  assign sample.valid = sample_valid;
  assign sample.data  = sample_data;

endmodule

`default_nettype wire

// ==== verilog/adc_frame_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_frame_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic rx_en,
  input  logic sclk_fall,
  input  logic sclk_mid,
  output logic spi_cs_n,
  output logic sclk_run,
  output logic shift_stb,
  output logic frame_end
);

  import adc_spi_pkg::*;

  localparam int HALF      = `ADC_SCLK_HALF;
  localparam int WAIT_W    = $clog2(HALF);
  localparam int DATA_END  = `ADC_LEAD_BITS + `ADC_DATA_BITS;
  // From the last mid strobe to the cycle before the would-be 17th fall.
  localparam int TAIL_WAIT = HALF - HALF / 2 - 2;

  frame_state_t      state;
  sclk_idx_t         fall_idx;
  sclk_idx_t         fall_idx_nxt;
  logic [WAIT_W-1:0] wait_cnt;
  logic              last_mid;

  assign fall_idx_nxt = fall_idx + 1'b1;

  // Middle of the high phase after fall 16.
  assign last_mid = (state == FRAME_TAIL) && sclk_run && sclk_mid &&
                    (fall_idx == sclk_idx_t'(`ADC_FRAME_BITS));

  assign shift_stb = (state == FRAME_DATA) && sclk_mid;
  assign frame_end = (state == FRAME_TAIL) && !sclk_run &&
                     (wait_cnt == WAIT_W'(TAIL_WAIT));

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      state    <= FRAME_IDLE;
      spi_cs_n <= 1'b1;
      sclk_run <= 1'b0;
      fall_idx <= '0;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        FRAME_IDLE:
        begin
          if (rx_en)
          begin
            state    <= FRAME_LEAD;
            spi_cs_n <= 1'b0;
            sclk_run <= 1'b1;
            fall_idx <= '0;
          end
        end
        FRAME_LEAD:
        begin
          if (sclk_fall)
          begin
            fall_idx <= fall_idx_nxt;
            if (fall_idx_nxt == sclk_idx_t'(`ADC_LEAD_BITS))
            begin
              state <= FRAME_DATA;       // MSB is on the pin after this fall.
            end
          end
        end
        FRAME_DATA:
        begin
          if (sclk_fall)
          begin
            fall_idx <= fall_idx_nxt;
            if (fall_idx_nxt == sclk_idx_t'(DATA_END))
            begin
              state <= FRAME_TAIL;
            end
          end
        end
        FRAME_TAIL:
        begin
          if (sclk_fall)
          begin
            fall_idx <= fall_idx_nxt;
          end
          else if (last_mid)
          begin
            sclk_run <= 1'b0;            // SCLK parks high for the rest of the frame.
            wait_cnt <= '0;
          end
          else if (frame_end)
          begin
            state    <= FRAME_QUIET;
            spi_cs_n <= 1'b1;
            wait_cnt <= '0;
          end
          else if (!sclk_run)
          begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        FRAME_QUIET:
        begin
          // Idle takes the last high cycle of the gap.
          if (wait_cnt == WAIT_W'(HALF - 2))
          begin
            state <= FRAME_IDLE;
          end
          else
          begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= FRAME_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/adc_sclk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "adc_spi_config.svh"

module adc_sclk_gen (
  input  logic clk,
  input  logic rst,
  input  logic sclk_run,
  output logic spi_sclk,
  output logic sclk_fall,
  output logic sclk_mid
);

  localparam int HALF  = `ADC_SCLK_HALF;
  localparam int CNT_W = $clog2(HALF);

  logic [CNT_W-1:0] half_cnt;
  logic             half_done;

  assign half_done = (half_cnt == CNT_W'(HALF - 1));

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      half_cnt  <= '0;
      spi_sclk  <= 1'b1;                  // Idle level is high.
      sclk_fall <= 1'b0;
      sclk_mid  <= 1'b0;
    end
    else if (!sclk_run)
    begin
      half_cnt  <= '0;
      spi_sclk  <= 1'b1;
      sclk_fall <= 1'b0;
      sclk_mid  <= 1'b0;
    end
    else
    begin
      if (half_done)
      begin
        half_cnt <= '0;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
      spi_sclk  <= spi_sclk ^ half_done;
      sclk_fall <= half_done && spi_sclk;  // High to low toggle.
      sclk_mid  <= spi_sclk && (half_cnt == CNT_W'(HALF / 2 - 1));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/adc_spi_pkg.sv ====
`default_nettype none

`include "adc_spi_config.svh"

package adc_spi_pkg;

  typedef logic [`ADC_DATA_BITS-1:0] adc_sample_t;

  // Wide enough for a full group without overflow.
  typedef logic [`ADC_DATA_BITS+`ADC_AVG_LOG2-1:0] adc_sum_t;

  typedef logic [$clog2(`ADC_FRAME_BITS + 1)-1:0] sclk_idx_t;  // Must hold the last index.

  typedef enum logic [2:0] {
    FRAME_IDLE,
    FRAME_LEAD,
    FRAME_DATA,
    FRAME_TAIL,
    FRAME_QUIET
  } frame_state_t;

  typedef struct packed {
    logic        valid;
    adc_sample_t data;
  } adc_sample_s;

  typedef struct packed {
    logic        valid;
    adc_sample_t mean;
  } adc_avg_s;

endpackage

`default_nettype wire

// ==== verilog/adc_spi_config.svh ====
`ifndef ADC_SPI_CONFIG_SVH
`define ADC_SPI_CONFIG_SVH

// clk cycles per SCLK half period.
`define ADC_SCLK_HALF 13

// SCLK periods in one conversion frame.
`define ADC_FRAME_BITS 16

// Leading zero bits ahead of the MSB.
`define ADC_LEAD_BITS 4

// Sample width.
`define ADC_DATA_BITS 10

// Averaging group holds 2**ADC_AVG_LOG2 samples.
`define ADC_AVG_LOG2 2

`endif
